// File: verilog/rv_pkg.sv
package rv_pkg;

  // datapath and memory geometry
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int mem_words  = 1024;
  localparam int strb_w     = 4;

  // major opcodes
  localparam logic [6:0] op_load     = 7'b0000011;
  localparam logic [6:0] op_store    = 7'b0100011;
  localparam logic [6:0] op_branch   = 7'b1100011;
  localparam logic [6:0] op_jalr     = 7'b1100111;
  localparam logic [6:0] op_jal      = 7'b1101111;
  localparam logic [6:0] op_misc_mem = 7'b0001111;
  localparam logic [6:0] op_reg_imm  = 7'b0010011;
  localparam logic [6:0] op_reg_reg  = 7'b0110011;
  localparam logic [6:0] op_environ  = 7'b1110011;
  localparam logic [6:0] op_auipc    = 7'b0010111;
  localparam logic [6:0] op_lui      = 7'b0110111;

  // alu operations
  localparam logic [3:0] alu_add  = 4'd0;
  localparam logic [3:0] alu_sub  = 4'd1;
  localparam logic [3:0] alu_sll  = 4'd2;
  localparam logic [3:0] alu_slt  = 4'd3;
  localparam logic [3:0] alu_sltu = 4'd4;
  localparam logic [3:0] alu_xor  = 4'd5;
  localparam logic [3:0] alu_srl  = 4'd6;
  localparam logic [3:0] alu_sra  = 4'd7;
  localparam logic [3:0] alu_or   = 4'd8;
  localparam logic [3:0] alu_and  = 4'd9;

  // writeback source select
  localparam logic [1:0] wb_alu   = 2'd0;
  localparam logic [1:0] wb_load  = 2'd1;
  localparam logic [1:0] wb_link  = 2'd2;
  localparam logic [1:0] wb_upper = 2'd3;

  // one instruction word seen through each encoding format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } insn_t;

endpackage

// File: verilog/rv_decoder.sv
`timescale 1ns/100ps

module rv_decoder (
  input  rv_pkg::insn_t                insn,
  output logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [rv_pkg::reg_addr_w-1:0] rd_addr,
  output logic [rv_pkg::xlen-1:0]       imm,
  output logic [3:0]                    alu_op,
  output logic                          alu_use_imm,
  output logic                          rd_we,
  output logic [1:0]                    wb_sel,
  output logic                          is_load,
  output logic                          is_store,
  output logic                          is_branch,
  output logic                          is_jal,
  output logic                          is_jalr,
  output logic                          is_auipc,
  output logic [2:0]                    funct3,
  output logic                          halt
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic       is_alu;

  assign opcode   = insn.r.opcode;
  assign rs1_addr = insn.r.rs1;
  assign rs2_addr = insn.r.rs2;
  assign rd_addr  = insn.r.rd;
  assign funct3   = insn.r.funct3;

  assign is_load   = opcode == op_load;
  assign is_store  = opcode == op_store;
  assign is_branch = opcode == op_branch;
  assign is_jal    = opcode == op_jal;
  assign is_jalr   = opcode == op_jalr;
  assign is_auipc  = opcode == op_auipc;
  assign is_alu    = opcode == op_reg_imm || opcode == op_reg_reg;

  // ecall only, every other field zero
  assign halt = opcode == op_environ && insn.u.imm == '0 && insn.u.rd == '0;

  assign alu_use_imm = opcode != op_reg_reg;
  assign rd_we = is_alu || is_load || is_jal || is_jalr || is_auipc || opcode == op_lui;

  always_comb begin
    if (is_load) begin
      wb_sel = wb_load;
    end else if (is_jal || is_jalr) begin
      wb_sel = wb_link;
    end else if (is_auipc || opcode == op_lui) begin
      wb_sel = wb_upper;
    end else begin
      wb_sel = wb_alu;
    end
  end

  // immediate format follows the opcode
  always_comb begin
    case (opcode)
      op_store:         imm = {{20{insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};
      op_branch:        imm = {{19{insn.b.imm12}}, insn.b.imm12, insn.b.imm11,
                               insn.b.imm10_5, insn.b.imm4_1, 1'b0};
      op_lui, op_auipc: imm = {insn.u.imm, 12'b0};
      op_jal:           imm = {{11{insn.j.imm20}}, insn.j.imm20, insn.j.imm19_12,
                               insn.j.imm11, insn.j.imm10_1, 1'b0};
      default:          imm = {{20{insn.i.imm[11]}}, insn.i.imm};
    endcase
  end

  // loads, stores and jalr all use the adder
  always_comb begin
    alu_op = alu_add;
    if (is_alu) begin
      case (insn.r.funct3)
        3'b000:  alu_op = (opcode == op_reg_reg && insn.r.funct7[5]) ? alu_sub : alu_add;
        3'b001:  alu_op = alu_sll;
        3'b010:  alu_op = alu_slt;
        3'b011:  alu_op = alu_sltu;
        3'b100:  alu_op = alu_xor;
        3'b101:  alu_op = insn.r.funct7[5] ? alu_sra : alu_srl;
        3'b110:  alu_op = alu_or;
        default: alu_op = alu_and;
      endcase
    end
  end

endmodule

// File: verilog/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data,
  input  logic [rv_pkg::reg_addr_w-1:0] rd_addr,
  input  logic [rv_pkg::xlen-1:0]       rd_data,
  input  logic                          rd_we
);
  import rv_pkg::*;

  // x0 has no storage
  logic [xlen-1:0] regs [1:2**reg_addr_w-1];

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 1; r < 2**reg_addr_w; r++) begin
        regs[r] <= '0;
      end
    end else if (rd_we && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

endmodule

// File: verilog/rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  input  logic [3:0]              alu_op,
  output logic [rv_pkg::xlen-1:0] result
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // shift amount is the low five bits only
  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (alu_op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = $unsigned($signed(a) >>> shamt);
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = a + b;
    endcase
  end

endmodule

// File: verilog/rv_lsu.sv
`timescale 1ns/100ps

module rv_lsu (
  input  logic [rv_pkg::xlen-1:0]   addr,
  input  logic [rv_pkg::xlen-1:0]   store_src,
  input  logic [2:0]                funct3,
  input  logic                      is_load,
  input  logic                      is_store,
  input  logic [rv_pkg::xlen-1:0]   mem_rdata,
  output logic [rv_pkg::xlen-1:0]   data_addr,
  output logic [rv_pkg::xlen-1:0]   data_wdata,
  output logic [rv_pkg::strb_w-1:0] data_wstrb,
  output logic [rv_pkg::xlen-1:0]   load_data
);
  import rv_pkg::*;

  logic [4:0]        lane_shift;
  logic [xlen-1:0]   rdata_lane;
  logic [strb_w-1:0] size_mask;

  // byte offset in bits
  assign lane_shift = {addr[1:0], 3'b000};
  assign data_addr  = {addr[xlen-1:2], 2'b00};

  always_comb begin
    case (funct3[1:0])
      2'b00:   size_mask = 4'b0001;
      2'b01:   size_mask = 4'b0011;
      default: size_mask = 4'b1111;
    endcase
  end

  assign data_wdata = store_src << lane_shift;
  assign data_wstrb = is_store ? (size_mask << addr[1:0]) : '0;

  // selected lane moved down to bit zero
  assign rdata_lane = mem_rdata >> lane_shift;

  always_comb begin
    load_data = '0;
    if (is_load) begin
      case (funct3)
        3'b000:  load_data = {{24{rdata_lane[7]}}, rdata_lane[7:0]};
        3'b001:  load_data = {{16{rdata_lane[15]}}, rdata_lane[15:0]};
        3'b100:  load_data = {24'b0, rdata_lane[7:0]};
        3'b101:  load_data = {16'b0, rdata_lane[15:0]};
        default: load_data = mem_rdata;
      endcase
    end
  end

endmodule

// File: verilog/rv_pc_unit.sv
`timescale 1ns/100ps

module rv_pc_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    halt,
  input  logic                    is_branch,
  input  logic                    is_jal,
  input  logic                    is_jalr,
  input  logic [2:0]              funct3,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  input  logic [rv_pkg::xlen-1:0] imm,
  input  logic [rv_pkg::xlen-1:0] jalr_target,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic [rv_pkg::xlen-1:0] pc_plus4
);
  import rv_pkg::*;

  logic            taken;
  logic [xlen-1:0] next_pc;

  always_comb begin
    case (funct3)
      3'b000:  taken = rs1_data == rs2_data;
      3'b001:  taken = rs1_data != rs2_data;
      3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);
      3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  taken = rs1_data < rs2_data;
      3'b111:  taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    if (is_jalr) begin
      next_pc = {jalr_target[xlen-1:1], 1'b0};
    end else if (is_jal || (is_branch && taken)) begin
      next_pc = pc + imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  // a halted core keeps the ecall in decode
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (!halt) begin
      pc <= next_pc;
    end
  end

endmodule

// File: verilog/rv_mem.sv
`timescale 1ns/100ps

module rv_mem (
  input  logic                      clk,
  input  logic [rv_pkg::xlen-1:0]   fetch_addr,
  output rv_pkg::insn_t             fetch_data,
  input  logic [rv_pkg::xlen-1:0]   data_addr,
  input  logic [rv_pkg::xlen-1:0]   data_wdata,
  input  logic [rv_pkg::strb_w-1:0] data_wstrb,
  output logic [rv_pkg::xlen-1:0]   data_rdata
);
  import rv_pkg::*;

  logic [xlen-1:0]                mem [mem_words];
  logic [$clog2(mem_words)-1:0]   fetch_idx;
  logic [$clog2(mem_words)-1:0]   data_idx;

  initial begin
    $readmemh("verification/program.hex", mem);
  end

  // word index, upper address bits ignored
  assign fetch_idx = fetch_addr[$clog2(mem_words)+1:2];
  assign data_idx  = data_addr[$clog2(mem_words)+1:2];

  // reads see the contents from before this cycle's write
  assign fetch_data = mem[fetch_idx];
  assign data_rdata = mem[data_idx];

  always_ff @(posedge clk) begin
    for (int b = 0; b < strb_w; b++) begin
      if (data_wstrb[b]) begin
        mem[data_idx][8*b +: 8] <= data_wdata[8*b +: 8];
      end
    end
  end

endmodule

// File: verilog/rv_cpu.sv
`timescale 1ns/100ps

module rv_cpu (
  input  logic                      clk,
  input  logic                      rst,
  output logic                      halt,
  output logic [rv_pkg::xlen-1:0]   data_addr,
  output logic [rv_pkg::xlen-1:0]   data_wdata,
  output logic [rv_pkg::strb_w-1:0] data_wstrb
);
  import rv_pkg::*;

  insn_t                 insn;
  logic [xlen-1:0]       pc;
  logic [xlen-1:0]       pc_plus4;
  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic [reg_addr_w-1:0] rd_addr;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       rd_data;
  logic [xlen-1:0]       imm;
  logic [xlen-1:0]       alu_b;
  logic [xlen-1:0]       alu_result;
  logic [xlen-1:0]       mem_rdata;
  logic [xlen-1:0]       load_data;
  logic [xlen-1:0]       upper_value;
  logic [3:0]            alu_op;
  logic [2:0]            funct3;
  logic [1:0]            wb_sel;
  logic                  alu_use_imm;
  logic                  rd_we;
  logic                  is_load;
  logic                  is_store;
  logic                  is_branch;
  logic                  is_jal;
  logic                  is_jalr;
  logic                  is_auipc;

  rv_pc_unit pc_unit_i (
    .clk         (clk),
    .rst         (rst),
    .halt        (halt),
    .is_branch   (is_branch),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .funct3      (funct3),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .jalr_target (alu_result),
    .pc          (pc),
    .pc_plus4    (pc_plus4)
  );

  rv_mem mem_i (
    .clk        (clk),
    .fetch_addr (pc),
    .fetch_data (insn),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_wstrb (data_wstrb),
    .data_rdata (mem_rdata)
  );

  rv_decoder decoder_i (
    .insn        (insn),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rd_addr     (rd_addr),
    .imm         (imm),
    .alu_op      (alu_op),
    .alu_use_imm (alu_use_imm),
    .rd_we       (rd_we),
    .wb_sel      (wb_sel),
    .is_load     (is_load),
    .is_store    (is_store),
    .is_branch   (is_branch),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .is_auipc    (is_auipc),
    .funct3      (funct3),
    .halt        (halt)
  );

  rv_regfile regfile_i (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rd_we    (rd_we)
  );

  assign alu_b = alu_use_imm ? imm : rs2_data;

  rv_alu alu_i (
    .a      (rs1_data),
    .b      (alu_b),
    .alu_op (alu_op),
    .result (alu_result)
  );

  // alu result doubles as the effective address
  rv_lsu lsu_i (
    .addr       (alu_result),
    .store_src  (rs2_data),
    .funct3     (funct3),
    .is_load    (is_load),
    .is_store   (is_store),
    .mem_rdata  (mem_rdata),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_wstrb (data_wstrb),
    .load_data  (load_data)
  );

  // lui takes the immediate as is, auipc adds the pc
  assign upper_value = is_auipc ? pc + imm : imm;

  always_comb begin
    case (wb_sel)
      wb_load:  rd_data = load_data;
      wb_link:  rd_data = pc_plus4;
      wb_upper: rd_data = upper_value;
      default:  rd_data = alu_result;
    endcase
  end

endmodule

// File: verification/rv_cpu_sva.sv
`timescale 1ns/100ps

module rv_cpu_sva (
  input logic                      clk,
  input logic                      rst,
  input logic                      halt,
  input logic [rv_pkg::xlen-1:0]   data_addr,
  input logic [rv_pkg::xlen-1:0]   data_wdata,
  input logic [rv_pkg::strb_w-1:0] data_wstrb,
  input logic                      is_store,
  input logic [2:0]                funct3,
  input logic [rv_pkg::xlen-1:0]   eff_addr,
  input logic [rv_pkg::xlen-1:0]   store_src
);
  import rv_pkg::*;

  // slot that the program always branches or jumps around
  localparam logic [xlen-1:0] wrong_path_addr = 32'h0000_03f0;

  int unsigned fail_count = 0;

  // byte lanes a store of this size touches
  function automatic logic [strb_w-1:0] lane_strobe(logic [2:0] size, logic [1:0] offset);
    case (size[1:0])
      2'b00:   return 4'b0001 << offset;
      2'b01:   return offset[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  // low bits of the source must sit in the addressed lane
  function automatic logic lane_data_ok(logic [2:0] size, logic [1:0] offset,
                                        logic [xlen-1:0] wdata, logic [xlen-1:0] src);
    int byte_lo;
    int half_lo;
    byte_lo = 8 * int'(offset);
    half_lo = 16 * int'(offset[1]);
    case (size[1:0])
      2'b00:   return wdata[byte_lo +: 8] == src[7:0];
      2'b01:   return wdata[half_lo +: 16] == src[15:0];
      default: return wdata == src;
    endcase
  endfunction

  reset_quiet: assert property (@(posedge clk) $past(rst) |-> !halt && data_wstrb == '0)
    else begin
      fail_count++;
      $error("halt or a store strobe active during reset");
    end

  store_lanes: assert property (@(posedge clk) disable iff (rst)
    is_store |-> data_wstrb == lane_strobe(funct3, eff_addr[1:0]))
    else begin
      fail_count++;
      $error("store strobe 0x%0h does not match the lane rule", data_wstrb);
    end

  store_data: assert property (@(posedge clk) disable iff (rst)
    is_store |-> lane_data_ok(funct3, eff_addr[1:0], data_wdata, store_src))
    else begin
      fail_count++;
      $error("store data 0x%08h not placed in the addressed lane", data_wdata);
    end

  no_wrong_path: assert property (@(posedge clk) disable iff (rst)
    data_wstrb != '0 |-> data_addr != wrong_path_addr)
    else begin
      fail_count++;
      $error("store reached the wrong path slot");
    end

  halt_holds: assert property (@(posedge clk) disable iff (rst)
    halt |-> data_wstrb == '0 ##1 halt)
    else begin
      fail_count++;
      $error("halt dropped or a store happened after ecall");
    end

endmodule

bind rv_cpu rv_cpu_sva sva_i (
  .clk        (clk),
  .rst        (rst),
  .halt       (halt),
  .data_addr  (data_addr),
  .data_wdata (data_wdata),
  .data_wstrb (data_wstrb),
  .is_store   (is_store),
  .funct3     (funct3),
  .eff_addr   (alu_result),
  .store_src  (rs2_data)
);

// File: verification/rv_cpu_tb.sv
`timescale 1ns/100ps

module rv_cpu_tb;
  import rv_pkg::*;

  localparam int clk_period  = 8;
  localparam int prog_insns  = 70;
  localparam int num_results = 24;
  localparam int hold_cycles = 8;
  // every result is one sw into consecutive words from here
  localparam logic [xlen-1:0] result_base = 32'h0000_0200;

  logic              clk;
  logic              rst;
  logic              halt;
  logic [xlen-1:0]   data_addr;
  logic [xlen-1:0]   data_wdata;
  logic [strb_w-1:0] data_wstrb;

  string test_names [num_results] = '{
    "add", "sub", "sra", "srli", "slli", "slt", "sltu", "xori",
    "and_ori", "beq", "bne", "blt", "bge", "bltu", "bgeu", "lb",
    "lbu", "lh", "lhu", "lw", "lui", "auipc", "jal", "jalr"
  };

  // x5 = -7, x6 = 3, data word 0x11223344 patched by sb x5 and sh x14
  // link and auipc values follow the instruction addresses 0xf0 to 0x108
  logic [xlen-1:0] expected [num_results] = '{
    32'hffff_fffc, 32'h0000_000a, 32'hffff_ffff, 32'h0fff_ffff,
    32'h0000_0060, 32'h0000_0001, 32'h0000_0000, 32'hffff_ff09,
    32'h0000_0065, 32'h0000_0003, 32'h0000_0003, 32'h0000_0003,
    32'h0000_0003, 32'h0000_0003, 32'h0000_0003, 32'hffff_fff9,
    32'h0000_00f9, 32'hffff_ff09, 32'h0000_ff09, 32'hff09_f944,
    32'h1234_5000, 32'h0000_10f0, 32'h0000_00fc, 32'h0000_010c
  };

  bit seen [num_results];
  int passed = 0;
  int failed = 0;
  int errors = 0;

  rv_cpu dut_i (
    .clk        (clk),
    .rst        (rst),
    .halt       (halt),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_wstrb (data_wstrb)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic check_result(input int idx);
    if (seen[idx]) begin
      $display("result slot of test %s was written more than once", test_names[idx]);
      errors++;
    end
    seen[idx] = 1'b1;
    assert (data_wdata == expected[idx]) begin
      $display("[PASS] %s", test_names[idx]);
      passed++;
    end else begin
      $display("[FAIL] %s: expected 0x%08h, actual 0x%08h",
               test_names[idx], expected[idx], data_wdata);
      failed++;
    end
  endtask

  // stores are stable mid cycle
  always @(negedge clk) begin
    if (!rst && data_wstrb != '0 && data_addr >= result_base &&
        data_addr < result_base + 4 * num_results) begin
      check_result(int'((data_addr - result_base) >> 2));
    end
  end

  initial begin
    int missing;
    int sva_failures;
    missing = 0;
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    while (halt !== 1'b1) @(negedge clk);
    // let the core sit on ecall for a while
    repeat (hold_cycles) @(negedge clk);
    for (int i = 0; i < num_results; i++) begin
      if (!seen[i]) begin
        $display("test %s never stored its result", test_names[i]);
        missing++;
      end
    end
    sva_failures = dut_i.sva_i.fail_count;
    $display("tests %0d, passed %0d, failed %0d, missing %0d, assertion failures %0d",
             num_results, passed, failed, missing, sva_failures);
    if (failed == 0 && missing == 0 && errors == 0 && sva_failures == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // four cycles per instruction of the program is ample
  initial begin
    #(prog_insns * clk_period * 4);
    $display("timeout, the core did not reach ecall within %0d ns",
             prog_insns * clk_period * 4);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: rv_cpu.f
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_lsu.sv
verilog/rv_pc_unit.sv
verilog/rv_mem.sv
verilog/rv_cpu.sv
verification/rv_cpu_sva.sv
verification/rv_cpu_tb.sv

// File: Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := rv_cpu_tb
FILELIST   := rv_cpu.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/program.hex
// one 32-bit word per line, instruction words from byte address 0x000
// after the code, @c0 places the initial data word at byte address 0x300
20000113  // 0x000 addi x2, x0, 512   result base 0x200
30000193  // 0x004 addi x3, x0, 768   data base 0x300
3f000213  // 0x008 addi x4, x0, 1008  wrong path slot 0x3f0
ff900293  // 0x00c addi x5, x0, -7
00300313  // 0x010 addi x6, x0, 3
006283b3  // 0x014 add  x7, x5, x6
00712023  // 0x018 sw   x7, 0(x2)
40530433  // 0x01c sub  x8, x6, x5
00812223  // 0x020 sw   x8, 4(x2)
4062d4b3  // 0x024 sra  x9, x5, x6
00912423  // 0x028 sw   x9, 8(x2)
0042d513  // 0x02c srli x10, x5, 4
00a12623  // 0x030 sw   x10, 12(x2)
00531593  // 0x034 slli x11, x6, 5
00b12823  // 0x038 sw   x11, 16(x2)
0062a633  // 0x03c slt  x12, x5, x6
00c12a23  // 0x040 sw   x12, 20(x2)
0062b6b3  // 0x044 sltu x13, x5, x6
00d12c23  // 0x048 sw   x13, 24(x2)
0f02c713  // 0x04c xori x14, x5, 0x0f0
00e12e23  // 0x050 sw   x14, 28(x2)
00b2f7b3  // 0x054 and  x15, x5, x11
0057e793  // 0x058 ori  x15, x15, 5
02f12023  // 0x05c sw   x15, 32(x2)
0ff0000f  // 0x060 fence
00630463  // 0x064 beq  x6, x6, +8    taken
00022023  // 0x068 sw   x0, 0(x4)
02612223  // 0x06c sw   x6, 36(x2)
00631663  // 0x070 bne  x6, x6, +12   not taken
02612423  // 0x074 sw   x6, 40(x2)
0080006f  // 0x078 jal  x0, +8
00022023  // 0x07c sw   x0, 0(x4)
0062c463  // 0x080 blt  x5, x6, +8    taken
00022023  // 0x084 sw   x0, 0(x4)
02612623  // 0x088 sw   x6, 44(x2)
0062d663  // 0x08c bge  x5, x6, +12   not taken
02612823  // 0x090 sw   x6, 48(x2)
0080006f  // 0x094 jal  x0, +8
00022023  // 0x098 sw   x0, 0(x4)
0062e663  // 0x09c bltu x5, x6, +12   not taken
02612a23  // 0x0a0 sw   x6, 52(x2)
0080006f  // 0x0a4 jal  x0, +8
00022023  // 0x0a8 sw   x0, 0(x4)
0062f463  // 0x0ac bgeu x5, x6, +8    taken
00022023  // 0x0b0 sw   x0, 0(x4)
02612c23  // 0x0b4 sw   x6, 56(x2)
005180a3  // 0x0b8 sb   x5, 1(x3)
00e19123  // 0x0bc sh   x14, 2(x3)
00118a03  // 0x0c0 lb   x20, 1(x3)
03412e23  // 0x0c4 sw   x20, 60(x2)
0011ca83  // 0x0c8 lbu  x21, 1(x3)
05512023  // 0x0cc sw   x21, 64(x2)
00219b03  // 0x0d0 lh   x22, 2(x3)
05612223  // 0x0d4 sw   x22, 68(x2)
0021db83  // 0x0d8 lhu  x23, 2(x3)
05712423  // 0x0dc sw   x23, 72(x2)
0001ac03  // 0x0e0 lw   x24, 0(x3)
05812623  // 0x0e4 sw   x24, 76(x2)
12345937  // 0x0e8 lui  x18, 0x12345
05212823  // 0x0ec sw   x18, 80(x2)
00001997  // 0x0f0 auipc x19, 0x1
05312a23  // 0x0f4 sw   x19, 84(x2)
00800cef  // 0x0f8 jal  x25, +8
00022023  // 0x0fc sw   x0, 0(x4)
05912c23  // 0x100 sw   x25, 88(x2)
00000d97  // 0x104 auipc x27, 0
00cd8d67  // 0x108 jalr x26, 12(x27)
00022023  // 0x10c sw   x0, 0(x4)
05a12e23  // 0x110 sw   x26, 92(x2)
00000073  // 0x114 ecall
@c0
11223344  // 0x300 data word for the byte and half accesses
